// ==== verilog/lsuPkg.sv ====
package lsuPkg;

    // data and address width
    localparam int xlen = 32;

    localparam int sqnWidth = 7;   // store-queue number
    localparam int tagWidth = 7;   // destination tag

    // requester IDs at the memory controller
    localparam int rqIdWidth = 2;
    localparam logic [rqIdWidth-1:0] bypassRqId = 2'd2;

    // commands to the memory controller, held as a level by the requester
    typedef enum logic [1:0] {
        memcNone       = 2'd0,
        memcReadSingle = 2'd1
    } MemcCmd;

endpackage

// ==== verilog/bypassLsu.sv ====
`timescale 1ns/1ps

module bypassLsu #(
    parameter logic [lsuPkg::rqIdWidth-1:0] rqId = lsuPkg::bypassRqId
) (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           branchTaken,
    input  logic [lsuPkg::sqnWidth-1:0]    branchSqN,

    input  logic                           uopLdEn,
    input  logic                           uopLdValid,
    input  logic [lsuPkg::xlen-1:0]        uopLdAddr,
    input  logic [lsuPkg::sqnWidth-1:0]    uopLdSqN,
    input  logic [lsuPkg::tagWidth-1:0]    uopLdTagDst,
    input  logic                           uopLdExternal,
    output logic                           ldStall,

    input  logic                           stall,
    output logic                           outValid,
    output logic [lsuPkg::xlen-1:0]        outAddr,
    output logic [lsuPkg::sqnWidth-1:0]    outSqN,
    output logic [lsuPkg::tagWidth-1:0]    outTagDst,
    output logic                           outExternal,
    output logic [lsuPkg::xlen-1:0]        ldData,

    output lsuPkg::MemcCmd                 memcCmd,
    output logic [lsuPkg::xlen-3:0]        memcAddr,
    output logic [lsuPkg::rqIdWidth-1:0]   memcRqId,
    input  logic                           memcBusy,
    input  logic [lsuPkg::rqIdWidth-1:0]   memcBusyRqId,
    input  logic                           memcResultValid,
    input  logic [lsuPkg::xlen-1:0]        memcResult
);

    typedef enum logic [1:0] {
        stIdle,
        stRequest,
        stActive,
        stDone
    } LsuState;

    LsuState state;

    // the load being worked on
    logic                         activeValid;
    logic [lsuPkg::xlen-1:0]      activeAddr;
    logic [lsuPkg::sqnWidth-1:0]  activeSqN;
    logic [lsuPkg::tagWidth-1:0]  activeTagDst;
    logic                         activeExternal;
    logic [lsuPkg::xlen-1:0]      result;

    // sqN distance to the resolving branch, wraps with the queue
    logic signed [lsuPkg::sqnWidth-1:0] inAge;
    logic signed [lsuPkg::sqnWidth-1:0] activeAge;

    logic squashIn;
    logic squashActive;
    logic accept;

    assign inAge     = uopLdSqN - branchSqN;
    assign activeAge = activeSqN - branchSqN;

    // external loads have side effects and must never be dropped
    assign squashIn     = branchTaken && !uopLdExternal && (inAge > 0);
    assign squashActive = activeValid && branchTaken && !activeExternal && (activeAge > 0);

    assign accept = uopLdEn && uopLdValid && (state == stIdle) && !squashIn;

    always_comb begin
        ldStall  = uopLdValid && uopLdEn && (state != stIdle);
        outValid = (state == stDone) && activeValid && !squashActive;
    end

    assign outAddr     = activeAddr;
    assign outSqN      = activeSqN;
    assign outTagDst   = activeTagDst;
    assign outExternal = activeExternal;
    assign ldData      = result;

    assign memcRqId = rqId;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= stIdle;
            activeValid <= 1'b0;
            memcCmd     <= lsuPkg::memcNone;
        end else begin
            if (squashActive)
                activeValid <= 1'b0; // read keeps going, result is thrown away

            case (state)
                stIdle: begin
                    if (accept) begin
                        activeValid <= 1'b1;
                        memcCmd     <= lsuPkg::memcReadSingle;
                        state       <= stRequest;
                    end
                end
                stRequest: begin
                    // hold the command until the controller has taken it
                    if (memcBusy && memcBusyRqId == rqId) begin
                        memcCmd <= lsuPkg::memcNone;
                        state   <= stActive;
                    end
                end
                stActive: begin
                    if (memcResultValid) begin
                        if (activeValid && !squashActive)
                            state <= stDone;
                        else
                            state <= stIdle;
                    end
                end
                stDone: begin
                    if (!stall || !outValid) begin
                        activeValid <= 1'b0;
                        state       <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // micro-op fields and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            activeAddr     <= uopLdAddr;
            activeSqN      <= uopLdSqN;
            activeTagDst   <= uopLdTagDst;
            activeExternal <= uopLdExternal;
            memcAddr       <= uopLdAddr[lsuPkg::xlen-1:2];
        end
        if (state == stActive && memcResultValid)
            result <= memcResult;
    end

endmodule

// ==== verilog/memController.sv ====
`timescale 1ns/1ps

module memController (
    input  logic                           clk,
    input  logic                           rst,

    input  lsuPkg::MemcCmd                 memcCmd,
    input  logic [lsuPkg::xlen-3:0]        memcAddr,
    input  logic [lsuPkg::rqIdWidth-1:0]   memcRqId,
    output logic                           memcBusy,
    output logic [lsuPkg::rqIdWidth-1:0]   memcBusyRqId,
    output logic                           memcResultValid,
    output logic [lsuPkg::xlen-1:0]        memcResult,

    output logic                           extRdEn,
    output logic [lsuPkg::xlen-3:0]        extRdAddr,
    input  logic [lsuPkg::xlen-1:0]        extRdData,
    input  logic                           extRdValid
);

    typedef enum logic [1:0] {
        stIdle,
        stIssue,
        stWait
    } MemcState;

    MemcState state;

    logic startRead;

    assign startRead = (state == stIdle) && (memcCmd == lsuPkg::memcReadSingle);

    // busy covers the whole transfer, from issue until the result pulse
    assign memcBusy = (state != stIdle);
    assign extRdEn  = (state == stIssue); // one cycle only

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= stIdle;
            memcResultValid <= 1'b0;
        end else begin
            memcResultValid <= 1'b0;

            case (state)
                stIdle: begin
                    if (startRead)
                        state <= stIssue;
                end
                stIssue: begin
                    state <= stWait;
                end
                stWait: begin
                    // external latency is unbounded
                    if (extRdValid) begin
                        memcResultValid <= 1'b1;
                        state           <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // requester ID is echoed back so the owner can recognise its own transfer
    always_ff @(posedge clk) begin
        if (startRead) begin
            memcBusyRqId <= memcRqId;
            extRdAddr    <= memcAddr;
        end
        if (state == stWait && extRdValid)
            memcResult <= extRdData;
    end

endmodule

// ==== verilog/uncachedLoadTop.sv ====
`timescale 1ns/1ps

module uncachedLoadTop (
    input  logic                           clk,
    input  logic                           rst,

    // load micro-op from issue
    input  logic                           uopLdEn,
    input  logic                           uopLdValid,
    input  logic [lsuPkg::xlen-1:0]        uopLdAddr,
    input  logic [lsuPkg::sqnWidth-1:0]    uopLdSqN,
    input  logic [lsuPkg::tagWidth-1:0]    uopLdTagDst,
    input  logic                           uopLdExternal,
    output logic                           ldStall,

    // branch resolution pulse
    input  logic                           branchTaken,
    input  logic [lsuPkg::sqnWidth-1:0]    branchSqN,

    // writeback
    input  logic                           stall,
    output logic                           outValid,
    output logic [lsuPkg::xlen-1:0]        outAddr,
    output logic [lsuPkg::tagWidth-1:0]    outTagDst,
    output logic [lsuPkg::sqnWidth-1:0]    outSqN,
    output logic                           outExternal,
    output logic [lsuPkg::xlen-1:0]        ldData,

    // external memory port
    output logic                           extRdEn,
    output logic [lsuPkg::xlen-3:0]        extRdAddr,
    input  logic [lsuPkg::xlen-1:0]        extRdData,
    input  logic                           extRdValid
);

    lsuPkg::MemcCmd                 memcCmd;
    logic [lsuPkg::xlen-3:0]        memcAddr;
    logic [lsuPkg::rqIdWidth-1:0]   memcRqId;
    logic                           memcBusy;
    logic [lsuPkg::rqIdWidth-1:0]   memcBusyRqId;
    logic                           memcResultValid;
    logic [lsuPkg::xlen-1:0]        memcResult;

    bypassLsu #(
        .rqId(lsuPkg::bypassRqId)
    ) i_bypassLsu (
        .clk            (clk),
        .rst            (rst),
        .branchTaken    (branchTaken),
        .branchSqN      (branchSqN),
        .uopLdEn        (uopLdEn),
        .uopLdValid     (uopLdValid),
        .uopLdAddr      (uopLdAddr),
        .uopLdSqN       (uopLdSqN),
        .uopLdTagDst    (uopLdTagDst),
        .uopLdExternal  (uopLdExternal),
        .ldStall        (ldStall),
        .stall          (stall),
        .outValid       (outValid),
        .outAddr        (outAddr),
        .outSqN         (outSqN),
        .outTagDst      (outTagDst),
        .outExternal    (outExternal),
        .ldData         (ldData),
        .memcCmd        (memcCmd),
        .memcAddr       (memcAddr),
        .memcRqId       (memcRqId),
        .memcBusy       (memcBusy),
        .memcBusyRqId   (memcBusyRqId),
        .memcResultValid(memcResultValid),
        .memcResult     (memcResult)
    );

    memController i_memController (
        .clk            (clk),
        .rst            (rst),
        .memcCmd        (memcCmd),
        .memcAddr       (memcAddr),
        .memcRqId       (memcRqId),
        .memcBusy       (memcBusy),
        .memcBusyRqId   (memcBusyRqId),
        .memcResultValid(memcResultValid),
        .memcResult     (memcResult),
        .extRdEn        (extRdEn),
        .extRdAddr      (extRdAddr),
        .extRdData      (extRdData),
        .extRdValid     (extRdValid)
    );

endmodule

// ==== dv/tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== dv/uncachedLoad_assert.sv ====
`timescale 1ns/1ps

module uncachedLoadAssert (
    input logic                         clk,
    input logic                         rst,
    input logic                         uopLdEn,
    input logic                         uopLdValid,
    input logic [lsuPkg::sqnWidth-1:0]  uopLdSqN,
    input logic [lsuPkg::tagWidth-1:0]  uopLdTagDst,
    input logic                         uopLdExternal,
    input logic                         ldStall,
    input logic                         branchTaken,
    input logic [lsuPkg::sqnWidth-1:0]  branchSqN,
    input logic                         stall,
    input logic                         outValid,
    input logic [lsuPkg::xlen-1:0]      outAddr,
    input logic [lsuPkg::tagWidth-1:0]  outTagDst,
    input logic [lsuPkg::sqnWidth-1:0]  outSqN,
    input logic                         outExternal,
    input logic [lsuPkg::xlen-1:0]      ldData,
    input logic                         extRdEn,
    input logic                         extRdValid,
    input logic                         memcResultValid
);

    typedef enum logic [1:0] {
        refIdle,
        refWait,
        refHold
    } RefState;

    RefState refState;   // where the current load should be
    logic [lsuPkg::sqnWidth-1:0] trkSqN;
    logic [lsuPkg::tagWidth-1:0] trkTag;
    logic trkExt;
    logic trkKilled;
    logic trkSeen;       // outValid shown for the tracked load
    logic readOpen;      // external read issued, no data yet
    logic signed [lsuPkg::sqnWidth-1:0] inAge;
    logic signed [lsuPkg::sqnWidth-1:0] trkAge;
    logic inKill;
    logic trkKillNow;
    logic accepted;
    logic expOutValid;
    logic expLdStall;
    logic [lsuPkg::xlen-1:0] expData;
    int failCount = 0;

    assign inAge       = uopLdSqN - branchSqN;
    assign trkAge      = trkSqN - branchSqN;
    assign inKill      = branchTaken && !uopLdExternal && (inAge > 0);
    assign trkKillNow  = branchTaken && !trkExt && (trkAge > 0);
    assign accepted    = uopLdValid && uopLdEn && (refState == refIdle) && !inKill;
    assign expOutValid = (refState == refHold) && !trkKillNow;
    assign expLdStall  = uopLdValid && uopLdEn && (refState != refIdle);
    assign expData     = {2'b00, outAddr[lsuPkg::xlen-1:2]} ^ 32'hA5A5_0000;

    always_ff @(posedge clk) begin
        if (rst) begin
            refState  <= refIdle;
            trkKilled <= 1'b0;
            trkSeen   <= 1'b1;   // nothing pending yet
            readOpen  <= 1'b0;
        end else begin
            if (extRdEn)
                readOpen <= 1'b1;
            else if (extRdValid)
                readOpen <= 1'b0;
            if (outValid)
                trkSeen <= 1'b1;
            case (refState)
                refIdle: begin
                    if (accepted) begin
                        trkSqN    <= uopLdSqN;
                        trkTag    <= uopLdTagDst;
                        trkExt    <= uopLdExternal;
                        trkKilled <= 1'b0;
                        trkSeen   <= 1'b0;
                        refState  <= refWait;
                    end
                end
                refWait: begin
                    if (trkKillNow)
                        trkKilled <= 1'b1;
                    if (memcResultValid)
                        refState <= (trkKilled || trkKillNow) ? refIdle : refHold;
                end
                default: begin
                    if (trkKillNow)
                        trkKilled <= 1'b1;
                    if (!stall || trkKillNow)
                        refState <= refIdle;
                end
            endcase
        end
    end

    dataOk: assert property (@(posedge clk) disable iff (rst) outValid |-> ldData == expData)
        else begin
            failCount++;
            $error("[ERROR] ldData 0x%h, expected 0x%h", $sampled(ldData), $sampled(expData));
        end

    fieldsOk: assert property (@(posedge clk) disable iff (rst)
        outValid |-> outSqN == trkSqN && outTagDst == trkTag && outExternal == trkExt)
        else begin
            failCount++;
            $error("[ERROR] outSqN 0x%h outTagDst 0x%h outExternal 0x%h, expected 0x%h 0x%h 0x%h",
                $sampled(outSqN), $sampled(outTagDst), $sampled(outExternal),
                $sampled(trkSqN), $sampled(trkTag), $sampled(trkExt));
        end

    holdOk: assert property (@(posedge clk) disable iff (rst)
        outValid && stall |=> trkKillNow
            || (outValid && $stable(outTagDst) && $stable(ldData)))
        else begin failCount++; $error("held load changed or dropped under stall"); end

    squashOk: assert property (@(posedge clk) disable iff (rst) outValid |-> !trkKilled)
        else begin failCount++; $error("squashed load reached writeback"); end

    completeOk: assert property (@(posedge clk) disable iff (rst)
        accepted |-> trkSeen || trkKilled)
        else begin failCount++; $error("load finished without showing outValid"); end

    outValidOk: assert property (@(posedge clk) disable iff (rst)
        outValid == expOutValid)
        else begin
            failCount++;
            $error("[ERROR] outValid 0x%h, expected 0x%h",
                $sampled(outValid), $sampled(expOutValid));
        end

    ldStallOk: assert property (@(posedge clk) disable iff (rst)
        ldStall == expLdStall)
        else begin
            failCount++;
            $error("[ERROR] ldStall 0x%h, expected 0x%h",
                $sampled(ldStall), $sampled(expLdStall));
        end

    readOk: assert property (@(posedge clk) disable iff (rst) extRdEn |-> !readOpen)
        else begin failCount++; $error("second external read issued before data returned"); end

    resetOk: assert property (@(posedge clk) $fell(rst) |-> !outValid && !ldStall && !extRdEn)
        else begin failCount++; $error("outputs not quiet after reset"); end

endmodule

bind uncachedLoadTop uncachedLoadAssert i_uncachedLoadAssert (.*);

// ==== dv/uncachedLoadTb.sv ====
`timescale 1ns/1ps

module uncachedLoadTb;

    localparam int numLoads      = 60;
    localparam int cyclesPerLoad = 40;
    localparam int clkPeriod     = 8;
    localparam logic [31:0] seed = 32'h78eb3ea3;

    logic clk;
    logic rst;

    // a micro-op waits at the input through reset
    logic                          uopLdEn = 1'b1;
    logic                          uopLdValid = 1'b1;
    logic [lsuPkg::xlen-1:0]       uopLdAddr = '0;
    logic [lsuPkg::sqnWidth-1:0]   uopLdSqN = '0;
    logic [lsuPkg::tagWidth-1:0]   uopLdTagDst = '0;
    logic                          uopLdExternal = 1'b0;
    logic                          branchTaken = 1'b0;
    logic [lsuPkg::sqnWidth-1:0]   branchSqN = '0;
    logic                          stall = 1'b0;
    logic [lsuPkg::xlen-1:0]       extRdData = '0;
    logic                          extRdValid = 1'b0;

    logic                          ldStall;
    logic                          outValid;
    logic [lsuPkg::xlen-1:0]       outAddr;
    logic [lsuPkg::tagWidth-1:0]   outTagDst;
    logic [lsuPkg::sqnWidth-1:0]   outSqN;
    logic                          outExternal;
    logic [lsuPkg::xlen-1:0]       ldData;
    logic                          extRdEn;
    logic [lsuPkg::xlen-3:0]       extRdAddr;

    // one generator state per process
    logic [31:0] stimRand = seed;
    logic [31:0] memRand = ~seed;
    logic [31:0] noiseRand = {seed[15:0], seed[31:16]};
    logic        noiseOn = 1'b0;

    logic                    memBusy = 1'b0;
    logic [2:0]              memWait = '0;
    logic [lsuPkg::xlen-3:0] memAddr = '0;

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    tbClock #(.periodNs(clkPeriod), .resetCycles(5)) i_tbClock (.clk(clk), .rst(rst));

    uncachedLoadTop i_uncachedLoadTop (.*);

    // external memory, one read at a time, 1 to 6 cycles
    always @(posedge clk) begin
        extRdValid <= 1'b0;
        if (rst) begin
            memBusy <= 1'b0;
        end else if (memBusy) begin
            if (memWait == 3'd0) begin
                extRdValid <= 1'b1;
                extRdData  <= {2'b00, memAddr} ^ 32'hA5A5_0000;
                memBusy    <= 1'b0;
            end else begin
                memWait <= memWait - 3'd1;
            end
        end else if (extRdEn) begin
            memBusy <= 1'b1;
            memAddr <= extRdAddr;
            memWait <= 3'(memRand[31:16] % 16'd6);
            memRand <= lcgStep(memRand);
        end
    end

    // branch pulses and writeback stall
    always @(posedge clk) begin
        if (rst || !noiseOn) begin
            branchTaken <= 1'b0;
            stall       <= 1'b0;
        end else begin
            branchTaken <= (noiseRand[31:28] == 4'd0);
            branchSqN   <= noiseRand[22:16];
            stall       <= noiseRand[27];
            noiseRand   <= lcgStep(noiseRand);
        end
    end

    // present one micro-op and hold it until the unit takes it
    task automatic issueLoad(input logic forceExt);
        logic taken;
        repeat (stimRand[31:30]) @(posedge clk);
        stimRand = lcgStep(stimRand);
        uopLdValid    <= 1'b1;
        uopLdEn       <= 1'b1;
        uopLdAddr     <= stimRand;
        stimRand = lcgStep(stimRand);
        uopLdSqN      <= stimRand[30:24];
        uopLdTagDst   <= stimRand[22:16];
        uopLdExternal <= forceExt || (stimRand[15:14] == 2'd0);
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = uopLdEn && !ldStall;
            @(posedge clk);
            stimRand = lcgStep(stimRand);
            if (!taken)
                uopLdEn <= (stimRand[31:29] != 3'd0);  // drop enable now and then
        end
        uopLdValid <= 1'b0;
        uopLdEn    <= stimRand[28];
    endtask

    initial begin
        do @(negedge clk); while (rst);
        @(posedge clk);
        noiseOn <= 1'b1;
        for (int ld = 0; ld < numLoads; ld++)
            issueLoad(1'b0);
        @(posedge clk);
        noiseOn <= 1'b0;
        issueLoad(1'b1);   // last one must complete
        do @(negedge clk); while (!outValid);
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (i_uncachedLoadTop.i_uncachedLoadAssert.failCount == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "assertion failures at end of run");
        end
    end

    always @(negedge clk) begin
        if (i_uncachedLoadTop.i_uncachedLoadAssert.failCount != 0) begin
            $display("Errors found");
            $fatal(1, "assertion failed in uncachedLoadTop");
        end
    end

    initial begin
        #(numLoads * cyclesPerLoad * clkPeriod);
        $display("Errors found");
        $fatal(1, "timeout: the loads did not complete in time");
    end

endmodule

// ==== filelist.f ====
verilog/lsuPkg.sv
verilog/bypassLsu.sv
verilog/memController.sv
verilog/uncachedLoadTop.sv
dv/tbClock.sv
dv/uncachedLoad_assert.sv
dv/uncachedLoadTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the uncached load testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        --top-module uncachedLoadTb -f filelist.f; then
    echo "build failed"
    exit 1
fi

simOut=$(./obj_dir/VuncachedLoadTb +verilator+error+limit+100)
simStatus=$?
printf '%s\n' "$simOut"

if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    echo "FAIL"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -q "^No errors$"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
